//--- verilog/fpu_config.svh
// ********************
// fpu configuration
// register count, word width and
// the wishbone address map of the fp side unit
// ********************
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// register file shape
`define FPU_NUM_REGS 32
`define FPU_XLEN 32

// wishbone address map, byte addresses
`define FPU_ADR_W 8
`define FPU_ADR_CMD 8'h00
`define FPU_ADR_FCSR 8'h04
`define FPU_ADR_RESULT 8'h08
// register i sits at base + 4*i
`define FPU_ADR_FREG_BASE 8'h80

`endif

//--- verilog/fpu_pkg.sv
// ********************
// fpu package
// operation codes, fflags bit positions,
// command word layout and canonical nan
// ********************
package fpu_pkg;

  // non-arithmetic single precision operations
  typedef enum logic [3:0] {
    OP_FSGNJ  = 4'd0,
    OP_FSGNJN = 4'd1,
    OP_FSGNJX = 4'd2,
    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,
    OP_FEQ    = 4'd5,
    OP_FLT    = 4'd6,
    OP_FLE    = 4'd7,
    OP_FCLASS = 4'd8
  } fp_op_e;

  // bit positions within fflags
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  // fcsr field widths, frm sits above fflags
  localparam int FLAGS_W = 5;
  localparam int FRM_W = 3;

  // command word layout
  localparam int REG_IDX_W = 5;
  localparam int CMD_OP_W = 4;
  localparam int CMD_OP_LSB = 16;
  localparam int CMD_RD_LSB = 10;
  localparam int CMD_RS1_LSB = 5;
  localparam int CMD_RS2_LSB = 0;

  // quiet nan returned when both min/max inputs are nan
  localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;

endpackage

//--- verilog/f_register_file.sv
// ********************
// fp register file
// 32 single precision registers, two
// combinational read ports, one write port
// ********************
`timescale 1ns/1ps
`include "fpu_config.svh"

module f_register_file (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic [fpu_pkg::REG_IDX_W-1:0]   rs1,
  input  logic [fpu_pkg::REG_IDX_W-1:0]   rs2,
  input  logic [fpu_pkg::REG_IDX_W-1:0]   rd,
  input  logic                            wen,
  input  logic [`FPU_XLEN-1:0]            w_data,
  output logic [`FPU_XLEN-1:0]            rs1_data,
  output logic [`FPU_XLEN-1:0]            rs2_data
);

  logic [`FPU_XLEN-1:0] regs [`FPU_NUM_REGS];

  // f0 is never written, so it keeps its reset value of zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `FPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= w_data;
    end
  end

  // read ports, no bypass
  // a write lands on the clock edge and is seen by the next access
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // f0 pinned at zero, whatever the bus tries
  a_f0_zero: assert property (
    @(posedge CLK) disable iff (!nRST) regs[0] == '0
  ) else $error("f0 holds a nonzero value");

endmodule

//--- verilog/fp_misc_unit.sv
// ********************
// fp misc unit
// sign injection, min/max, compares and
// classify, with invalid flag generation
// ********************
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_misc_unit (
  input  fpu_pkg::fp_op_e                 op,
  input  logic [`FPU_XLEN-1:0]            a,
  input  logic [`FPU_XLEN-1:0]            b,
  output logic [`FPU_XLEN-1:0]            fp_result,
  output logic [`FPU_XLEN-1:0]            int_result,
  output logic                            writes_fp,
  output logic [fpu_pkg::FLAGS_W-1:0]     flags
);

  // operand fields
  logic a_sign, b_sign;
  logic a_exp_max, b_exp_max;
  logic a_exp_zero, b_exp_zero;
  logic a_man_zero, b_man_zero;
  // operand classes
  logic a_nan, b_nan, a_snan, b_snan;
  logic a_inf, a_zero, a_sub;
  logic both_zero;
  // ordering
  logic lt, eq, mm_lt;
  logic [9:0] cls;

  assign a_sign = a[31];
  assign b_sign = b[31];
  assign a_exp_max = &a[30:23];
  assign b_exp_max = &b[30:23];
  assign a_exp_zero = ~|a[30:23];
  assign b_exp_zero = ~|b[30:23];
  assign a_man_zero = ~|a[22:0];
  assign b_man_zero = ~|b[22:0];

  // nan with mantissa msb clear is signaling
  assign a_nan = a_exp_max && !a_man_zero;
  assign b_nan = b_exp_max && !b_man_zero;
  assign a_snan = a_nan && !a[22];
  assign b_snan = b_nan && !b[22];
  assign a_inf = a_exp_max && a_man_zero;
  assign a_zero = a_exp_zero && a_man_zero;
  assign a_sub = a_exp_zero && !a_man_zero;
  assign both_zero = a_zero && b_exp_zero && b_man_zero;

  // ieee ordering for non-nan inputs, +0 == -0
  always_comb begin
    if (a_sign != b_sign) begin
      lt = a_sign && !both_zero;
    end else if (!a_sign) begin
      lt = a[30:0] < b[30:0];
    end else begin
      lt = a[30:0] > b[30:0];
    end
  end
  assign eq = (a == b) || both_zero;
  // min/max order puts -0 below +0
  assign mm_lt = lt || (both_zero && a_sign && !b_sign);

  // class mask in standard bit order, negative side first
  assign cls[0] = a_sign && a_inf;
  assign cls[1] = a_sign && !a_exp_zero && !a_exp_max;
  assign cls[2] = a_sign && a_sub;
  assign cls[3] = a_sign && a_zero;
  assign cls[4] = !a_sign && a_zero;
  assign cls[5] = !a_sign && a_sub;
  assign cls[6] = !a_sign && !a_exp_zero && !a_exp_max;
  assign cls[7] = !a_sign && a_inf;
  assign cls[8] = a_snan;
  assign cls[9] = a_nan && a[22];

  always_comb begin
    fp_result = '0;
    int_result = '0;
    writes_fp = 1'b0;
    flags = '0;
    case (op)
      fpu_pkg::OP_FSGNJ: begin
        fp_result = {b_sign, a[30:0]};
        writes_fp = 1'b1;
      end
      fpu_pkg::OP_FSGNJN: begin
        fp_result = {!b_sign, a[30:0]};
        writes_fp = 1'b1;
      end
      fpu_pkg::OP_FSGNJX: begin
        fp_result = {a_sign ^ b_sign, a[30:0]};
        writes_fp = 1'b1;
      end
      fpu_pkg::OP_FMIN, fpu_pkg::OP_FMAX: begin
        writes_fp = 1'b1;
        flags[fpu_pkg::FLAG_NV] = a_snan || b_snan;
        if (a_nan && b_nan) begin
          fp_result = fpu_pkg::CANON_NAN;
        end else if (a_nan) begin
          fp_result = b;
        end else if (b_nan) begin
          fp_result = a;
        end else if (op == fpu_pkg::OP_FMIN) begin
          fp_result = mm_lt ? a : b;
        end else begin
          fp_result = mm_lt ? b : a;
        end
      end
      // quiet compare, only snan is invalid
      fpu_pkg::OP_FEQ: begin
        int_result[0] = !a_nan && !b_nan && eq;
        flags[fpu_pkg::FLAG_NV] = a_snan || b_snan;
      end
      // signaling compares
      fpu_pkg::OP_FLT: begin
        int_result[0] = !a_nan && !b_nan && lt;
        flags[fpu_pkg::FLAG_NV] = a_nan || b_nan;
      end
      fpu_pkg::OP_FLE: begin
        int_result[0] = !a_nan && !b_nan && (lt || eq);
        flags[fpu_pkg::FLAG_NV] = a_nan || b_nan;
      end
      fpu_pkg::OP_FCLASS: begin
        int_result[9:0] = cls;
      end
      default: begin
        // unused codes do nothing and raise no flag
        fp_result = '0;
      end
    endcase
  end

  // every encoding of a lands in exactly one class
  always_comb begin
    if (!$isunknown(a)) begin
      a_cls_onehot: assert ($onehot(cls))
        else $error("fclass mask not one-hot for %h", a);
    end
  end

endmodule

//--- verilog/fp_csr.sv
// ********************
// fcsr
// rounding mode and sticky exception flags
// ********************
`timescale 1ns/1ps

module fp_csr (
  input  logic                                           CLK,
  input  logic                                           nRST,
  input  logic                                           flag_en,
  input  logic [fpu_pkg::FLAGS_W-1:0]                    flags,
  input  logic                                           csr_we,
  input  logic [fpu_pkg::FRM_W+fpu_pkg::FLAGS_W-1:0]     csr_w_data,
  output logic [fpu_pkg::FRM_W+fpu_pkg::FLAGS_W-1:0]     fcsr
);

  logic [fpu_pkg::FRM_W-1:0] frm;
  logic [fpu_pkg::FLAGS_W-1:0] fflags;

  // host write replaces both fields
  // a finished command only ever adds flags
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      frm <= '0;
      fflags <= '0;
    end else if (csr_we) begin
      frm <= csr_w_data[fpu_pkg::FLAGS_W +: fpu_pkg::FRM_W];
      fflags <= csr_w_data[fpu_pkg::FLAGS_W-1:0];
    end else if (flag_en) begin
      fflags <= fflags | flags;
    end
  end

  // frm in 7:5, fflags in 4:0
  assign fcsr = {frm, fflags};

  // bus slave issues one strobe per access
  // so a merge would never be lost to a host write
  a_no_we_merge: assert property (
    @(posedge CLK) disable iff (!nRST) !(flag_en && csr_we)
  ) else $error("flag merge and csr write in the same cycle");

endmodule

//--- verilog/fpu_wb_slave.sv
// ********************
// fpu wishbone slave
// address decode, two cycle handshake,
// write strobes and read data select
// ********************
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_wb_slave (
  input  logic                                         CLK,
  input  logic                                         nRST,
  input  logic                                         wb_cyc,
  input  logic                                         wb_stb,
  input  logic                                         wb_we,
  input  logic [`FPU_ADR_W-1:0]                        wb_adr,
  input  logic [`FPU_XLEN-1:0]                         wb_dat_w,
  input  logic [3:0]                                   wb_sel,
  output logic [`FPU_XLEN-1:0]                         wb_dat_r,
  output logic                                         wb_ack,
  output logic [fpu_pkg::REG_IDX_W-1:0]                rs1,
  output logic [fpu_pkg::REG_IDX_W-1:0]                rs2,
  output logic [fpu_pkg::REG_IDX_W-1:0]                rd,
  output logic                                         wen,
  output logic [`FPU_XLEN-1:0]                         w_data,
  output fpu_pkg::fp_op_e                              op,
  output logic                                         flag_en,
  output logic                                         csr_we,
  output logic [fpu_pkg::FRM_W+fpu_pkg::FLAGS_W-1:0]   csr_w_data,
  input  logic [`FPU_XLEN-1:0]                         rs1_data,
  input  logic [`FPU_XLEN-1:0]                         fp_result,
  input  logic [`FPU_XLEN-1:0]                         int_result,
  input  logic                                         writes_fp,
  input  logic [fpu_pkg::FLAGS_W-1:0]                  flags,
  input  logic [fpu_pkg::FRM_W+fpu_pkg::FLAGS_W-1:0]   fcsr
);

  logic req;
  logic wr_acc;
  logic is_cmd, is_fcsr, is_result, is_freg;
  logic [`FPU_ADR_W-1:0] freg_off;
  logic [fpu_pkg::REG_IDX_W-1:0] freg_idx;
  logic [`FPU_XLEN-1:0] result_q;

  assign req = wb_cyc && wb_stb;

  // ack one cycle after the request and low for the next one
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req && !wb_ack;
    end
  end

  // register window covers 0x80..0xfc
  assign freg_off = wb_adr - `FPU_ADR_FREG_BASE;
  assign freg_idx = freg_off[fpu_pkg::REG_IDX_W+1:2];
  assign is_cmd = wb_adr == `FPU_ADR_CMD;
  assign is_fcsr = wb_adr == `FPU_ADR_FCSR;
  assign is_result = wb_adr == `FPU_ADR_RESULT;
  assign is_freg = (wb_adr >= `FPU_ADR_FREG_BASE) && (wb_adr[1:0] == 2'b00);

  // strobes fire in the ack cycle on full word writes only
  assign wr_acc = wb_ack && req && wb_we && (wb_sel == 4'hF);

  // command fields straight off the write data
  assign op = fpu_pkg::fp_op_e'(wb_dat_w[fpu_pkg::CMD_OP_LSB +: fpu_pkg::CMD_OP_W]);
  assign rs2 = wb_dat_w[fpu_pkg::CMD_RS2_LSB +: fpu_pkg::REG_IDX_W];
  // register window reuses rs1 as the read port and rd as the store target
  assign rs1 = is_freg ? freg_idx : wb_dat_w[fpu_pkg::CMD_RS1_LSB +: fpu_pkg::REG_IDX_W];
  assign rd = is_freg ? freg_idx : wb_dat_w[fpu_pkg::CMD_RD_LSB +: fpu_pkg::REG_IDX_W];
  assign w_data = is_freg ? wb_dat_w : fp_result;

  assign wen = wr_acc && (is_freg || (is_cmd && writes_fp));
  assign flag_en = wr_acc && is_cmd;
  assign csr_we = wr_acc && is_fcsr;
  assign csr_w_data = wb_dat_w[fpu_pkg::FRM_W+fpu_pkg::FLAGS_W-1:0];

  // integer result of the last compare or classify
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_q <= '0;
    end else if (wr_acc && is_cmd && !writes_fp) begin
      result_q <= int_result;
    end
  end

  // command and unmapped addresses read zero
  always_comb begin
    wb_dat_r = '0;
    if (is_fcsr) begin
      wb_dat_r = {{(`FPU_XLEN-fpu_pkg::FRM_W-fpu_pkg::FLAGS_W){1'b0}}, fcsr};
    end else if (is_result) begin
      wb_dat_r = result_q;
    end else if (is_freg) begin
      wb_dat_r = rs1_data;
    end
  end

  // every access takes two cycles even back to back
  a_ack_single: assert property (
    @(posedge CLK) disable iff (!nRST) wb_ack |=> !wb_ack
  ) else $error("wishbone ack held for two cycles");

endmodule

//--- verilog/fpu_top.sv
// ********************
// fpu side unit top
// wishbone slave, fp register file,
// misc operation unit and fcsr
// ********************
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_top (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`FPU_ADR_W-1:0]     wb_adr,
  input  logic [`FPU_XLEN-1:0]      wb_dat_w,
  input  logic [3:0]                wb_sel,
  output logic [`FPU_XLEN-1:0]      wb_dat_r,
  output logic                      wb_ack
);

  // register file side
  logic [fpu_pkg::REG_IDX_W-1:0] rs1, rs2, rd;
  logic wen;
  logic [`FPU_XLEN-1:0] w_data, rs1_data, rs2_data;
  // operation unit side
  fpu_pkg::fp_op_e op;
  logic [`FPU_XLEN-1:0] fp_result, int_result;
  logic writes_fp;
  logic [fpu_pkg::FLAGS_W-1:0] flags;
  // csr side
  logic flag_en, csr_we;
  logic [fpu_pkg::FRM_W+fpu_pkg::FLAGS_W-1:0] csr_w_data, fcsr;

  fpu_wb_slave fpu_wb_slave_i (
    .CLK(CLK), .nRST(nRST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .rs1(rs1), .rs2(rs2), .rd(rd), .wen(wen), .w_data(w_data), .op(op),
    .flag_en(flag_en), .csr_we(csr_we), .csr_w_data(csr_w_data),
    .rs1_data(rs1_data), .fp_result(fp_result), .int_result(int_result),
    .writes_fp(writes_fp), .flags(flags), .fcsr(fcsr)
  );

  f_register_file f_register_file_i (
    .CLK(CLK), .nRST(nRST), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(wen),
    .w_data(w_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // rs1 is operand a, rs2 operand b
  fp_misc_unit fp_misc_unit_i (
    .op(op), .a(rs1_data), .b(rs2_data), .fp_result(fp_result),
    .int_result(int_result), .writes_fp(writes_fp), .flags(flags)
  );

  fp_csr fp_csr_i (
    .CLK(CLK), .nRST(nRST), .flag_en(flag_en), .flags(flags),
    .csr_we(csr_we), .csr_w_data(csr_w_data), .fcsr(fcsr)
  );

endmodule

//--- verification/fpu_tb.sv
// ********************
// fpu side unit testbench
// replays wishbone accesses from a stimulus
// file and compares read data with expected values
// ********************
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_tb;

  localparam int CLK_HALF = 50;
  localparam int DRIVE_DLY = 5;
  localparam int ACK_WAIT = 4;
  // five words per stimulus line
  localparam int STIM_LINES = 128;
  localparam int STIM_WORDS = STIM_LINES * 5;
  localparam logic [31:0] KIND_WRITE = 32'd1;
  localparam logic [31:0] KIND_READ = 32'd2;

  logic CLK;
  logic nRST;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [`FPU_ADR_W-1:0] wb_adr;
  logic [`FPU_XLEN-1:0] wb_dat_w;
  logic [3:0] wb_sel;
  logic [`FPU_XLEN-1:0] wb_dat_r;
  logic wb_ack;

  logic [31:0] stim [0:STIM_WORDS-1];
  int n_lines;
  bit loaded;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;

  fpu_top fpu_top_i (
    .CLK(CLK), .nRST(nRST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  // 100 ns clock
  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // one wishbone classic access entered and left at edge plus drive delay
  task automatic bus_access(input logic we, input logic [7:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    waited = 0;
    rdat = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    wb_sel = 4'hF;
    // request held until ack shows up
    while (!wb_ack && waited < ACK_WAIT) begin
      @(posedge CLK);
      #DRIVE_DLY;
      waited++;
    end
    if (!wb_ack) begin
      $display("no ack from the DUT within %0d cycles for address %h", ACK_WAIT, adr);
      errors++;
      test_errors++;
    end else begin
      rdat = wb_dat_r;
      // ack answers on the clock after the request
      check("wb_ack delay in cycles", waited, 32'd1);
    end
    // write strobe lands on this edge and the bus goes idle after it
    @(posedge CLK);
    #DRIVE_DLY;
    // ack drops again with the request still up
    check("wb_ack", {31'b0, wb_ack}, 32'd0);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic report_test(input int num);
    if (test_errors == 0) begin
      $display("test %0d passed", num);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", num, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // run limit grows with the stimulus length
  initial begin
    int limit;
    wait (loaded);
    limit = n_lines * 4 + 50;
    repeat (limit) @(posedge CLK);
    $display("watchdog expired, run did not finish within %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] kind;
    logic [31:0] rdat;
    logic [31:0] exp;
    int cur_test;
    int tnum;
    nRST = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = 4'h0;
    errors = 0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    loaded = 1'b0;
    // kind 0 marks the end of the stimulus
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("verification/fpu_stim.txt", stim);
    n_lines = 0;
    while (n_lines < STIM_LINES && stim[5 * n_lines] != 32'd0) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      $display("stimulus file is missing or holds no accesses");
      errors++;
    end
    loaded = 1'b1;
    // reset held for two cycles and released on the drive slot
    repeat (2) @(posedge CLK);
    #DRIVE_DLY;
    nRST = 1'b1;
    cur_test = int'(stim[4]);
    for (int i = 0; i < n_lines; i++) begin
      kind = stim[5 * i];
      exp = stim[5 * i + 3];
      tnum = int'(stim[5 * i + 4]);
      // a new test number closes the previous test
      if (tnum != cur_test) begin
        report_test(cur_test);
        cur_test = tnum;
      end
      bus_access(kind == KIND_WRITE, stim[5 * i + 1][7:0], stim[5 * i + 2], rdat);
      if (kind == KIND_READ) begin
        check($sformatf("wb_dat_r at address %h", stim[5 * i + 1][7:0]), rdat, exp);
      end
    end
    if (n_lines > 0) begin
      report_test(cur_test);
    end
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verification/fpu_stim.txt
// columns: kind (1 write, 2 read and compare), address, write data, expected read data, test
// registers at 80 + 4*i, command 00, fcsr 04, result 08
2 80 00000000 00000000 1
2 94 00000000 00000000 1
2 FC 00000000 00000000 1
2 04 00000000 00000000 1
2 08 00000000 00000000 1
1 80 3F800000 00000000 1
2 80 00000000 00000000 1
1 94 C0490FDB 00000000 1
2 94 00000000 C0490FDB 1
1 84 3F800000 00000000 2
1 88 C0000000 00000000 2
1 00 00000C22 00000000 2
2 8C 00000000 BF800000 2
1 00 00011022 00000000 2
2 90 00000000 3F800000 2
1 00 000214A2 00000000 2
2 94 00000000 40490FDB 2
1 00 00011841 00000000 2
2 98 00000000 C0000000 2
1 9C 80000000 00000000 3
1 A0 00000000 00000000 3
1 A4 7FC12345 00000000 3
1 A8 7F800001 00000000 3
1 00 00032D07 00000000 3
2 AC 00000000 80000000 3
1 00 00042CE8 00000000 3
2 AC 00000000 00000000 3
1 00 00043121 00000000 3
2 B0 00000000 3F800000 3
1 00 00033529 00000000 3
2 B4 00000000 7FC00000 3
2 04 00000000 00000000 3
1 00 00033941 00000000 3
2 B8 00000000 3F800000 3
2 04 00000000 00000010 3
1 00 00050107 00000000 4
2 08 00000000 00000001 4
1 00 00060041 00000000 4
2 08 00000000 00000001 4
1 00 00070022 00000000 4
2 08 00000000 00000000 4
1 00 000700E8 00000000 4
2 08 00000000 00000001 4
1 04 00000000 00000000 4
2 04 00000000 00000000 4
1 00 00050121 00000000 4
2 08 00000000 00000000 4
2 04 00000000 00000000 4
1 00 00060121 00000000 4
2 08 00000000 00000000 4
2 04 00000000 00000010 4
1 BC FF800000 00000000 5
1 00 000801E0 00000000 5
2 08 00000000 00000001 5
1 00 00080040 00000000 5
2 08 00000000 00000002 5
1 00 000800E0 00000000 5
2 08 00000000 00000008 5
1 BC 00000001 00000000 5
1 00 000801E0 00000000 5
2 08 00000000 00000020 5
1 BC 7F800000 00000000 5
1 00 000801E0 00000000 5
2 08 00000000 00000080 5
1 00 00080140 00000000 5
2 08 00000000 00000100 5
1 00 00080120 00000000 5
2 08 00000000 00000200 5
2 04 00000000 00000010 6
1 00 00000C22 00000000 6
2 04 00000000 00000010 6
1 04 00000060 00000000 6
2 04 00000000 00000060 6
1 00 00043941 00000000 6
2 04 00000000 00000070 6
2 B8 00000000 3F800000 6
2 0C 00000000 00000000 6
1 0C 12345678 00000000 6
2 0C 00000000 00000000 6
2 00 00000000 00000000 6
2 82 00000000 00000000 6

//--- all.f
+incdir+verilog
verilog/fpu_pkg.sv
verilog/f_register_file.sv
verilog/fp_misc_unit.sv
verilog/fp_csr.sv
verilog/fpu_wb_slave.sv
verilog/fpu_top.sv
verification/fpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fpu testbench with verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --assert -j 0 --top-module fpu_tb -f all.f -o fpu_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/fpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
